// ==== Makefile ====
# Verilator build and run for the system-control block

VERILATOR  ?= verilator
TOP        ?= tb_hk_sysctrl
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_ARGS   ?= +verilator+error+limit+1000
FAIL_MSG   ?= Test FAILED
PASS_MSG   ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "No pass message found in $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hk_sysctrl_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module hk_sysctrl_checker (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      wb_cyc_i,
    input  wire                      wb_stb_i,
    input  wire                      wb_ack_i,
    input  hk_sysctrl_pkg::wb_data_t wb_dat_i,
    input  hk_sysctrl_pkg::pad_sel_t pad_out_i,
    input  hk_sysctrl_pkg::irq_sel_t user_irq_i,
    input  wire [31:0]               step_no_i,
    input  wire [3:0]                step_op_i,
    input  wire                      exp_ack_i,
    input  hk_sysctrl_pkg::wb_data_t exp_rdata_i,
    input  hk_sysctrl_pkg::pad_sel_t exp_pads_i,
    input  hk_sysctrl_pkg::irq_sel_t exp_irq_i,
    input  wire                      step_done_i,
    output logic [31:0]              steps_run_o,
    output logic [31:0]              steps_failed_o,
    output logic [31:0]              errors_o
);

    int   req_edges = 0;
    int   ack_count = 0;
    int   step_errs = 0;
    logic bus_op;

    initial begin
        steps_run_o    = '0;
        steps_failed_o = '0;
        errors_o       = '0;
    end

    assign bus_op = (step_op_i == 4'h1) || (step_op_i == 4'h2);

    function automatic string op_name(input logic [3:0] op);
        case (op)
            4'h0:    return "idle";
            4'h1:    return "write";
            4'h2:    return "read";
            4'h3:    return "pin set";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Mismatch at %0t: step %0d %s is %0h, expected %0h",
                 $time, step_no_i, what, got, want);
        step_errs++;
    endtask

    task automatic report_failure(input string text);
        $display("Step %0d failed at %0t: %s", step_no_i, $time, text);
        step_errs++;
    endtask

    // Sampled on the rising edge where the driver's inputs have been stable
    // since 1 ns after the previous edge
    always @(posedge clk) begin
        if (resetn) begin
            if (wb_ack_i) begin
                ack_count++;
                if (!bus_op || !exp_ack_i) begin
                    report_failure("the slave acknowledged a request that must not be answered");
                end else if (ack_count > 1) begin
                    report_failure("a second acknowledge arrived in the same access");
                end else begin
                    if (req_edges != 1) begin
                        report_failure($sformatf("the acknowledge came %0d cycles after the request",
                                                 req_edges));
                    end
                    if (step_op_i == 4'h2 && wb_dat_i !== exp_rdata_i) begin
                        report_mismatch("read data", wb_dat_i, exp_rdata_i);
                    end
                    // Pads must already follow a write while its ack is high
                    if (pad_out_i !== exp_pads_i) begin
                        report_mismatch("pad outputs during ack", 32'(pad_out_i),
                                        32'(exp_pads_i));
                    end
                end
            end else if (wb_cyc_i && wb_stb_i) begin
                req_edges++;
            end

            if (step_done_i) begin
                if (bus_op && exp_ack_i && ack_count == 0) begin
                    report_failure("the request was never acknowledged");
                end
                if (!(bus_op && exp_ack_i) && pad_out_i !== exp_pads_i) begin
                    report_mismatch("pad outputs", 32'(pad_out_i), 32'(exp_pads_i));
                end
                if (user_irq_i !== exp_irq_i) begin
                    report_mismatch("interrupt lines", 32'(user_irq_i), 32'(exp_irq_i));
                end
                steps_run_o++;
                if (step_errs != 0) begin
                    steps_failed_o++;
                end
                errors_o += step_errs;
                $display("Step %0d %s: %s", step_no_i, op_name(step_op_i),
                         (step_errs == 0) ? "ok" : "failed");
                req_edges = 0;
                ack_count = 0;
                step_errs = 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hk_sysctrl_pkg.sv ====
`default_nettype none

package hk_sysctrl_pkg;

    // Wishbone bus fields
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

    // Power-good flags, bit 0 upward: usr1 vcc, usr2 vcc, usr1 vdd, usr2 vdd
    typedef logic [3:0] pwrgood_t;

    // Routed pad outputs, bit 0 is clk1, bit 1 is clk2, bit 2 is trap
    typedef logic [2:0] pad_sel_t;

    // User interrupt lines, bit 0 is irq 7 and bit 1 is irq 8
    typedef logic [1:0] irq_sel_t;

    // Base of the 256-byte register window
    // Only bits 31 to 8 take part in the window decode
    localparam wb_addr_t SYSCTRL_BASE = 32'h2F00_0000;

    // Word register offsets inside the window
    localparam logic [7:0] PWRGOOD_OFS  = 8'h00;
    localparam logic [7:0] CLK_OUT_OFS  = 8'h04;
    localparam logic [7:0] TRAP_OUT_OFS = 8'h08;
    localparam logic [7:0] IRQ_SRC_OFS  = 8'h0C;

endpackage

`default_nettype wire

// ==== hk_sysctrl_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module hk_sysctrl_properties (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      wb_cyc_i,
    input  wire                      wb_stb_i,
    input  hk_sysctrl_pkg::wb_addr_t wb_adr_i,
    input  wire                      wb_ack_i,
    input  wire                      clk1_dest_i,
    input  wire                      clk2_dest_i,
    input  wire                      trap_dest_i,
    input  wire                      irq7_src_i,
    input  wire                      irq8_src_i
);

    // Read by the testbench at the end of the run
    int unsigned fail_count = 0;

    logic in_window;
    logic routing_clear;

    assign in_window     = (wb_adr_i[31:8] == hk_sysctrl_pkg::SYSCTRL_BASE[31:8]);
    assign routing_clear = !(clk1_dest_i || clk2_dest_i || trap_dest_i ||
                             irq7_src_i || irq8_src_i);

    // The slave never acknowledges in two cycles back to back
    ack_single_cycle: assert property (@(posedge clk) disable iff (!resetn)
        wb_ack_i |=> !wb_ack_i)
        else begin
            fail_count++;
            $error("Acknowledge stayed high for two cycles in a row");
        end

    // An acknowledge always follows a request that hit the window
    ack_after_request: assert property (@(posedge clk) disable iff (!resetn)
        wb_ack_i |-> $past(wb_cyc_i && wb_stb_i && in_window))
        else begin
            fail_count++;
            $error("Acknowledge without a request inside the window one cycle earlier");
        end

    // A reset cycle leaves all routing bits and the acknowledge cleared
    reset_clears_routing: assert property (@(posedge clk)
        !resetn |=> (routing_clear && !wb_ack_i))
        else begin
            fail_count++;
            $error("Routing bits or acknowledge not cleared by reset");
        end

endmodule

bind sysctrl_regs hk_sysctrl_properties u_regs_props (
    .clk         (clk),
    .resetn      (resetn),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_adr_i    (wb_adr_i),
    .wb_ack_i    (wb_ack_o),
    .clk1_dest_i (clk1_dest_o),
    .clk2_dest_i (clk2_dest_o),
    .trap_dest_i (trap_dest_o),
    .irq7_src_i  (irq7_src_o),
    .irq8_src_i  (irq8_src_o)
);

`default_nettype wire

// ==== hk_sysctrl_testdata.txt ====
// op addr wdata sel pwrgood usr(trap,clk2,clk1) mgmt pad_in exp_rdata exp_pads exp_irq exp_ack
// op 0 idle, 1 write, 2 read, 3 pin set, F end; idle and pin set wait wdata cycles
// Values after reset
0 00000000 00000002 0 0 5 2 0 00000000 2 0 0
2 2F000004 00000000 F 0 5 2 0 00000000 2 0 1
2 2F000008 00000000 F 0 5 2 0 00000000 2 0 1
2 2F00000C 00000000 F 0 5 2 0 00000000 2 0 1
2 2F000000 00000000 F 0 5 2 0 00000000 2 0 1
// Clock and trap routing
1 2F000004 00000001 1 0 5 2 0 00000000 3 0 1
2 2F000004 00000000 F 0 5 2 0 00000001 3 0 1
1 2F000004 FFFFFFFE F 0 5 2 0 00000000 0 0 1
2 2F000004 00000000 F 0 5 2 0 00000002 0 0 1
1 2F000008 00000001 1 0 5 2 0 00000000 4 0 1
2 2F000008 00000000 F 0 5 2 0 00000001 4 0 1
3 00000000 00000002 0 0 2 5 0 00000000 3 0 0
// Writes that must change nothing
1 2F000004 00000003 0 0 2 5 0 00000000 3 0 1
1 2F000004 00000001 E 0 2 5 0 00000000 3 0 1
2 2F000004 00000000 F 0 2 5 0 00000002 3 0 1
1 2F000000 0000000F F 0 2 5 0 00000000 3 0 1
2 2F000000 00000000 F 0 2 5 0 00000000 3 0 1
// Power-good bit order
3 00000000 00000004 0 9 2 5 0 00000000 3 0 0
2 2F000000 00000000 F 9 2 5 0 00000009 3 0 1
3 00000000 00000004 0 6 2 5 0 00000000 3 0 0
2 2F000000 00000000 F 6 2 5 0 00000006 3 0 1
// Interrupt sources
3 00000000 00000002 0 6 2 5 3 00000000 3 0 0
0 00000000 00000003 0 6 2 5 3 00000000 3 0 0
1 2F00000C 00000001 1 6 2 5 3 00000000 3 1 1
2 2F00000C 00000000 F 6 2 5 3 00000001 3 1 1
1 2F00000C 00000003 1 6 2 5 3 00000000 3 3 1
3 00000000 00000002 0 6 2 5 2 00000000 3 2 0
3 00000000 00000002 0 6 2 5 1 00000000 3 1 0
1 2F00000C 00000000 1 6 2 5 1 00000000 3 0 1
0 00000000 00000003 0 6 2 5 1 00000000 3 0 0
// Outside the window and unknown offsets
2 2F000104 00000000 F 6 2 5 1 00000000 3 0 0
1 30000004 00000000 F 6 2 5 1 00000000 3 0 0
2 2F000010 00000000 F 6 2 5 1 00000000 3 0 1
2 2F0000FC 00000000 F 6 2 5 1 00000000 3 0 1
2 2F000004 00000000 F 6 2 5 1 00000002 3 0 1
F 00000000 00000000 0 0 0 0 0 00000000 0 0 0

// ==== hk_sysctrl_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module hk_sysctrl_top (
    input  wire                      clk,
    input  wire                      resetn,

    input  wire                      wb_cyc_i,
    input  wire                      wb_stb_i,
    input  wire                      wb_we_i,
    input  hk_sysctrl_pkg::wb_sel_t  wb_sel_i,
    input  hk_sysctrl_pkg::wb_addr_t wb_adr_i,
    input  hk_sysctrl_pkg::wb_data_t wb_dat_i,
    output hk_sysctrl_pkg::wb_data_t wb_dat_o,
    output wire                      wb_ack_o,

    input  hk_sysctrl_pkg::pwrgood_t pwrgood_i,

    input  wire                      user_clk1_i,
    input  wire                      user_clk2_i,
    input  wire                      trap_i,
    input  hk_sysctrl_pkg::pad_sel_t mgmt_pad_out_i,
    output hk_sysctrl_pkg::pad_sel_t pad_out_o,

    input  hk_sysctrl_pkg::irq_sel_t pad_in_i,
    output hk_sysctrl_pkg::irq_sel_t user_irq_o
);

    hk_sysctrl_pkg::pwrgood_t pwrgood_synced;
    wire                      clk1_dest;
    wire                      clk2_dest;
    wire                      trap_dest;
    wire                      irq7_src;
    wire                      irq8_src;

    pwrgood_sync u_pwrgood_sync (
        .clk       (clk),
        .resetn    (resetn),
        .pwrgood_i (pwrgood_i),
        .pwrgood_o (pwrgood_synced)
    );

    sysctrl_regs u_sysctrl_regs (
        .clk         (clk),
        .resetn      (resetn),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_sel_i    (wb_sel_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .pwrgood_i   (pwrgood_synced),
        .clk1_dest_o (clk1_dest),
        .clk2_dest_o (clk2_dest),
        .trap_dest_o (trap_dest),
        .irq7_src_o  (irq7_src),
        .irq8_src_o  (irq8_src)
    );

    // Pad outputs follow a write in the same cycle as its ack
    pad_route u_pad_route (
        .clk            (clk),
        .resetn         (resetn),
        .clk1_dest_i    (clk1_dest),
        .clk2_dest_i    (clk2_dest),
        .trap_dest_i    (trap_dest),
        .irq7_src_i     (irq7_src),
        .irq8_src_i     (irq8_src),
        .user_clk1_i    (user_clk1_i),
        .user_clk2_i    (user_clk2_i),
        .trap_i         (trap_i),
        .mgmt_pad_out_i (mgmt_pad_out_i),
        .pad_out_o      (pad_out_o),
        .pad_in_i       (pad_in_i),
        .user_irq_o     (user_irq_o)
    );

endmodule

`default_nettype wire

// ==== pad_route.sv ====
`timescale 1ns/100ps
`default_nettype none

module pad_route (
    input  wire                      clk,
    input  wire                      resetn,

    input  wire                      clk1_dest_i,
    input  wire                      clk2_dest_i,
    input  wire                      trap_dest_i,
    input  wire                      irq7_src_i,
    input  wire                      irq8_src_i,

    input  wire                      user_clk1_i,
    input  wire                      user_clk2_i,
    input  wire                      trap_i,
    input  hk_sysctrl_pkg::pad_sel_t mgmt_pad_out_i,
    output hk_sysctrl_pkg::pad_sel_t pad_out_o,

    input  hk_sysctrl_pkg::irq_sel_t pad_in_i,
    output hk_sysctrl_pkg::irq_sel_t user_irq_o
);

    hk_sysctrl_pkg::irq_sel_t pad_meta_q;
    hk_sysctrl_pkg::irq_sel_t pad_sync_q;
    hk_sysctrl_pkg::irq_sel_t irq_en;

    // Each pad takes its routed source when the destination bit is set,
    // and otherwise keeps the management output
    assign pad_out_o[0] = clk1_dest_i ? user_clk1_i : mgmt_pad_out_i[0];
    assign pad_out_o[1] = clk2_dest_i ? user_clk2_i : mgmt_pad_out_i[1];
    assign pad_out_o[2] = trap_dest_i ? trap_i      : mgmt_pad_out_i[2];

    // Pad inputs come straight from the package pins
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pad_meta_q <= '0;
            pad_sync_q <= '0;
        end else begin
            pad_meta_q <= pad_in_i;
            pad_sync_q <= pad_meta_q;
        end
    end

    assign irq_en = {irq8_src_i, irq7_src_i};

    // Line 7 sits in bit 0 and line 8 in bit 1
    assign user_irq_o = pad_sync_q & irq_en;

endmodule

`default_nettype wire

// ==== pwrgood_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module pwrgood_sync (
    input  wire                      clk,
    input  wire                      resetn,
    input  hk_sysctrl_pkg::pwrgood_t pwrgood_i,
    output hk_sysctrl_pkg::pwrgood_t pwrgood_o
);

    // The supply monitors switch with no relation to clk, so every flag
    // goes through two flops before the register file may sample it
    hk_sysctrl_pkg::pwrgood_t meta_q;
    hk_sysctrl_pkg::pwrgood_t sync_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= pwrgood_i;
            sync_q <= meta_q;
        end
    end

    // A pin change shows up here two edges after it is first sampled
    assign pwrgood_o = sync_q;

endmodule

`default_nettype wire

// ==== sysctrl_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module sysctrl_regs (
    input  wire                      clk,
    input  wire                      resetn,

    input  wire                      wb_cyc_i,
    input  wire                      wb_stb_i,
    input  wire                      wb_we_i,
    input  hk_sysctrl_pkg::wb_sel_t  wb_sel_i,
    input  hk_sysctrl_pkg::wb_addr_t wb_adr_i,
    input  hk_sysctrl_pkg::wb_data_t wb_dat_i,
    output hk_sysctrl_pkg::wb_data_t wb_dat_o,
    output logic                     wb_ack_o,

    input  hk_sysctrl_pkg::pwrgood_t pwrgood_i,

    output logic                     clk1_dest_o,
    output logic                     clk2_dest_o,
    output logic                     trap_dest_o,
    output logic                     irq7_src_o,
    output logic                     irq8_src_o
);

    logic                     req;
    logic                     win_hit;
    logic                     access;
    hk_sysctrl_pkg::wb_sel_t  wr_lane;
    logic                     wr_lane0;
    logic [7:0]               ofs;
    logic                     clk_out_sel;
    logic                     trap_out_sel;
    logic                     irq_sel;
    hk_sysctrl_pkg::wb_data_t rd_word;
    hk_sysctrl_pkg::wb_data_t rdata_q;

    // A bus request is cyc and stb together
    assign req = wb_cyc_i && wb_stb_i;

    // Per-lane write enables, only lane 0 holds register bits
    assign wr_lane  = wb_sel_i & {4{wb_we_i}};
    assign wr_lane0 = wr_lane[0];

    assign win_hit = (wb_adr_i[31:8] == hk_sysctrl_pkg::SYSCTRL_BASE[31:8]);
    assign ofs     = wb_adr_i[7:0];

    // The ack of the previous cycle blocks a second ack while the master
    // still holds stb in the cycle it sees the first one
    assign access = req && win_hit && !wb_ack_o;

    assign clk_out_sel  = (ofs == hk_sysctrl_pkg::CLK_OUT_OFS);
    assign trap_out_sel = (ofs == hk_sysctrl_pkg::TRAP_OUT_OFS);
    assign irq_sel      = (ofs == hk_sysctrl_pkg::IRQ_SRC_OFS);

    // Readback word for the addressed register; unknown offsets read zero
    always_comb begin
        rd_word = '0;
        case (ofs)
            hk_sysctrl_pkg::PWRGOOD_OFS:  rd_word[3:0] = pwrgood_i;
            hk_sysctrl_pkg::CLK_OUT_OFS:  rd_word[1:0] = {clk2_dest_o, clk1_dest_o};
            hk_sysctrl_pkg::TRAP_OUT_OFS: rd_word[0]   = trap_dest_o;
            hk_sysctrl_pkg::IRQ_SRC_OFS:  rd_word[1:0] = {irq8_src_o, irq7_src_o};
            default:                      rd_word      = '0;
        endcase
    end

    // Acknowledge and routing bits
    // The power-good register is read only, so it has no write branch
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_ack_o    <= 1'b0;
            clk1_dest_o <= 1'b0;
            clk2_dest_o <= 1'b0;
            trap_dest_o <= 1'b0;
            irq7_src_o  <= 1'b0;
            irq8_src_o  <= 1'b0;
        end else begin
            wb_ack_o <= access;
            if (access && wr_lane0) begin
                if (clk_out_sel) begin
                    clk1_dest_o <= wb_dat_i[0];
                    clk2_dest_o <= wb_dat_i[1];
                end
                if (trap_out_sel) begin
                    trap_dest_o <= wb_dat_i[0];
                end
                if (irq_sel) begin
                    irq7_src_o <= wb_dat_i[0];
                    irq8_src_o <= wb_dat_i[1];
                end
            end
        end
    end

    // Read data is captured on the acknowledging edge and holds the value
    // the register had before any write in the same access
    always_ff @(posedge clk) begin
        if (access) begin
            rdata_q <= rd_word;
        end
    end

    assign wb_dat_o = rdata_q;

endmodule

`default_nettype wire

// ==== tb_hk_sysctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_hk_sysctrl;

    localparam int NUM_FIELDS = 12;
    localparam int MAX_STEPS  = 64;
    localparam int ACK_WAIT   = 4;

    logic                     clk;
    logic                     resetn;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    hk_sysctrl_pkg::wb_sel_t  wb_sel;
    hk_sysctrl_pkg::wb_addr_t wb_adr;
    hk_sysctrl_pkg::wb_data_t wb_dat_w;
    hk_sysctrl_pkg::wb_data_t wb_dat_r;
    wire                      wb_ack;
    hk_sysctrl_pkg::pwrgood_t pwrgood;
    logic                     user_clk1;
    logic                     user_clk2;
    logic                     trap;
    hk_sysctrl_pkg::pad_sel_t mgmt_pad_out;
    hk_sysctrl_pkg::pad_sel_t pad_out;
    hk_sysctrl_pkg::irq_sel_t pad_in;
    hk_sysctrl_pkg::irq_sel_t user_irq;

    // Expected values of the running step, handed to the checker
    logic [31:0]              step_no;
    logic [3:0]               step_op;
    logic                     exp_ack;
    hk_sysctrl_pkg::wb_data_t exp_rdata;
    hk_sysctrl_pkg::pad_sel_t exp_pads;
    hk_sysctrl_pkg::irq_sel_t exp_irq;
    logic                     step_done;
    logic [31:0]              steps_run;
    logic [31:0]              steps_failed;
    logic [31:0]              check_errors;

    // One step is NUM_FIELDS consecutive words of the data file
    logic [31:0] stim_mem [0:MAX_STEPS*NUM_FIELDS-1];
    int          num_steps    = 0;
    logic        steps_loaded = 1'b0;
    int unsigned assert_fails;

    hk_sysctrl_top DUT (
        .clk            (clk),
        .resetn         (resetn),
        .wb_cyc_i       (wb_cyc),
        .wb_stb_i       (wb_stb),
        .wb_we_i        (wb_we),
        .wb_sel_i       (wb_sel),
        .wb_adr_i       (wb_adr),
        .wb_dat_i       (wb_dat_w),
        .wb_dat_o       (wb_dat_r),
        .wb_ack_o       (wb_ack),
        .pwrgood_i      (pwrgood),
        .user_clk1_i    (user_clk1),
        .user_clk2_i    (user_clk2),
        .trap_i         (trap),
        .mgmt_pad_out_i (mgmt_pad_out),
        .pad_out_o      (pad_out),
        .pad_in_i       (pad_in),
        .user_irq_o     (user_irq)
    );

    hk_sysctrl_checker u_checker (
        .clk            (clk),
        .resetn         (resetn),
        .wb_cyc_i       (wb_cyc),
        .wb_stb_i       (wb_stb),
        .wb_ack_i       (wb_ack),
        .wb_dat_i       (wb_dat_r),
        .pad_out_i      (pad_out),
        .user_irq_i     (user_irq),
        .step_no_i      (step_no),
        .step_op_i      (step_op),
        .exp_ack_i      (exp_ack),
        .exp_rdata_i    (exp_rdata),
        .exp_pads_i     (exp_pads),
        .exp_irq_i      (exp_irq),
        .step_done_i    (step_done),
        .steps_run_o    (steps_run),
        .steps_failed_o (steps_failed),
        .errors_o       (check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic step_op_valid(input logic [31:0] word);
        return (^word !== 1'bx) && (word < 32'd4);
    endfunction

    task automatic wait_cycles(input logic [31:0] count);
        repeat (count) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Holds the request until ack is seen, then through the ack cycle
    task automatic bus_access(input logic write, input hk_sysctrl_pkg::wb_addr_t addr,
                              input hk_sysctrl_pkg::wb_data_t data,
                              input hk_sysctrl_pkg::wb_sel_t sel);
        int   waited;
        logic got_ack;
        waited   = 0;
        got_ack  = 1'b0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = write;
        wb_adr   = addr;
        wb_dat_w = data;
        wb_sel   = sel;
        while (!got_ack && waited < ACK_WAIT) begin
            @(posedge clk);
            #1;
            waited++;
            got_ack = wb_ack;
        end
        if (got_ack) begin
            @(posedge clk);
            #1;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        wb_sel = '0;
    endtask

    task automatic finish_step();
        step_done = 1'b1;
        @(posedge clk);
        #1;
        step_done = 1'b0;
    endtask

    task automatic run_step(input int s);
        int         base;
        logic [3:0] op;
        base         = s * NUM_FIELDS;
        op           = stim_mem[base][3:0];
        step_no      = s + 1;
        step_op      = op;
        pwrgood      = stim_mem[base+4][3:0];
        user_clk1    = stim_mem[base+5][0];
        user_clk2    = stim_mem[base+5][1];
        trap         = stim_mem[base+5][2];
        mgmt_pad_out = stim_mem[base+6][2:0];
        pad_in       = stim_mem[base+7][1:0];
        exp_rdata    = stim_mem[base+8];
        exp_pads     = stim_mem[base+9][2:0];
        exp_irq      = stim_mem[base+10][1:0];
        exp_ack      = stim_mem[base+11][0];
        if (op == 4'h1 || op == 4'h2) begin
            bus_access(op == 4'h1, stim_mem[base+1], stim_mem[base+2], stim_mem[base+3][3:0]);
        end else begin
            wait_cycles(stim_mem[base+2]);
        end
        finish_step();
    endtask

    initial begin
        resetn       = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_sel       = '0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        pwrgood      = '0;
        user_clk1    = 1'b0;
        user_clk2    = 1'b0;
        trap         = 1'b0;
        mgmt_pad_out = '0;
        pad_in       = '0;
        step_no      = '0;
        step_op      = '0;
        exp_ack      = 1'b0;
        exp_rdata    = '0;
        exp_pads     = '0;
        exp_irq      = '0;
        step_done    = 1'b0;

        $readmemh("hk_sysctrl_testdata.txt", stim_mem);
        while (num_steps < MAX_STEPS && step_op_valid(stim_mem[num_steps*NUM_FIELDS])) begin
            num_steps++;
        end
        steps_loaded = 1'b1;

        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;

        for (int s = 0; s < num_steps; s++) begin
            run_step(s);
        end

        // A second reset has to clear the routing bits that the steps left set
        resetn = 1'b0;
        wait_cycles(2);
        resetn = 1'b1;

        @(posedge clk);
        #1;
        assert_fails = DUT.u_sysctrl_regs.u_regs_props.fail_count;
        $display("Steps run %0d of %0d, failed %0d, errors %0d, assertion failures %0d",
                 steps_run, num_steps, steps_failed, check_errors, assert_fails);
        if (num_steps > 0 && steps_run == num_steps && steps_failed == 0 &&
            check_errors == 0 && assert_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Twenty cycles per step is far more than the longest step needs
    initial begin
        wait (steps_loaded);
        repeat (num_steps * 20) @(posedge clk);
        $display("Watchdog expired after %0d cycles before all steps finished",
                 num_steps * 20);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hk_sysctrl_pkg.sv
pwrgood_sync.sv
sysctrl_regs.sv
pad_route.sv
hk_sysctrl_top.sv
hk_sysctrl_properties.sv
hk_sysctrl_checker.sv
tb_hk_sysctrl.sv
